/* sources.f */
verilog/zynq_pkg.sv
verilog/axil_csr_write.sv
verilog/axil_csr_read.sv
verilog/pl_reset_chain.sv
verilog/dram_addr_remap.sv
verilog/zynq_pl_top.sv
tb/zynq_pl_props.sv
tb/tb_zynq_pl_top.sv

/* tb/tb_zynq_pl_top.sv */
`timescale 1ns/1ps

module tb_zynq_pl_top
  import zynq_pkg::*;
;

  localparam int RESET_DEPTH = 3;
  localparam int NUM_REQ     = 100;
  localparam int NUM_REQ2    = 20;
  localparam int NUM_HOST    = 40;
  localparam int TOTAL_TXN   = 2 * (NUM_REQ + NUM_REQ2) + NUM_HOST;

  logic                   aclk;
  logic                   rst_n_i;
  logic [AXIL_ADDR_W-1:0] s_awaddr_i;
  logic                   s_awvalid_i;
  logic                   s_awready_o;
  logic [AXIL_DATA_W-1:0] s_wdata_i;
  logic [AXIL_STRB_W-1:0] s_wstrb_i;
  logic                   s_wvalid_i;
  logic                   s_wready_o;
  logic [1:0]             s_bresp_o;
  logic                   s_bvalid_o;
  logic                   s_bready_i;
  logic [AXIL_ADDR_W-1:0] s_araddr_i;
  logic                   s_arvalid_i;
  logic                   s_arready_o;
  logic [AXIL_DATA_W-1:0] s_rdata_o;
  logic [1:0]             s_rresp_o;
  logic                   s_rvalid_o;
  logic                   s_rready_i;
  cache_req_t             aw_req_i;
  logic                   aw_req_v_i;
  logic                   aw_req_ready_o;
  logic [M_ADDR_W-1:0]    m_awaddr_o;
  logic                   m_awvalid_o;
  logic                   m_awready_i;
  cache_req_t             ar_req_i;
  logic                   ar_req_v_i;
  logic                   ar_req_ready_o;
  logic [M_ADDR_W-1:0]    m_araddr_o;
  logic                   m_arvalid_o;
  logic                   m_arready_i;

  integer seed = 45885;
  int     errors = 0;
  int     checks = 0;
  logic [31:0] csr_model [NUM_CSR];
  logic [31:0] aw_q [$];
  logic [31:0] ar_q [$];
  logic [31:0] rd_data;
  logic [31:0] base;
  logic [3:0]  strb;
  logic [31:0] wr_data;

  zynq_pl_top #(.RESET_DEPTH(RESET_DEPTH)) uut (.*);

  always #4 aclk = ~aclk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  // zero pad, cache id, 27-bit offset, then the window base
  function automatic logic [31:0] expected_dram_addr(cache_req_t req, logic [31:0] b);
    return {1'b0, req.cache_id, req.addr[26:0]} + b;
  endfunction

  // called 1 ns after an edge, returns 1 ns after an edge
  task automatic host_write(input int idx, input logic [31:0] data, input logic [3:0] be);
    s_awaddr_i  = AXIL_ADDR_W'(idx << 2);
    s_wdata_i   = data;
    s_wstrb_i   = be;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    @(posedge aclk);
    while (!(s_awready_o && s_wready_o))
      @(posedge aclk);
    if (idx < NUM_CSR)
      csr_model[idx] = merge_bytes(csr_model[idx], data, be);
    #1;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b1;
    @(posedge aclk);
    while (!s_bvalid_o)
      @(posedge aclk);
    check_value("write_bresp", 32'd0, 32'(s_bresp_o));
    #1;
    s_bready_i = 1'b0;
  endtask

  task automatic host_read(input int idx, output logic [31:0] data);
    s_araddr_i  = AXIL_ADDR_W'(idx << 2);
    s_arvalid_i = 1'b1;
    @(posedge aclk);
    while (!s_arready_o)
      @(posedge aclk);
    #1;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b1;
    @(posedge aclk);
    while (!s_rvalid_o)
      @(posedge aclk);
    data = s_rdata_o;
    check_value("read_rresp", 32'd0, 32'(s_rresp_o));
    #1;
    s_rready_i = 1'b0;
  endtask

  task automatic wait_release();
    int cycles;
    cycles = 0;
    @(posedge aclk);
    while (!(aw_req_ready_o && ar_req_ready_o) && cycles < RESET_DEPTH + 2)
    begin
      cycles++;
      @(posedge aclk);
    end
    if (!(aw_req_ready_o && ar_req_ready_o))
    begin
      errors++;
      $display("request readies did not rise within %0d cycles of release", RESET_DEPTH + 2);
    end
    #1;
  endtask

  // random traffic on both remap channels against the queue model
  task automatic run_traffic(input int n, input logic [31:0] b);
    int   sent_aw;
    int   sent_ar;
    int   got_aw;
    int   got_ar;
    logic acc_aw;
    logic acc_ar;
    sent_aw = 0;
    sent_ar = 0;
    got_aw  = 0;
    got_ar  = 0;
    while (got_aw < n || got_ar < n)
    begin
      @(posedge aclk);
      acc_aw = aw_req_v_i && aw_req_ready_o;
      acc_ar = ar_req_v_i && ar_req_ready_o;
      if (acc_aw)
      begin
        aw_q.push_back(expected_dram_addr(aw_req_i, b));
        sent_aw++;
      end
      if (acc_ar)
      begin
        ar_q.push_back(expected_dram_addr(ar_req_i, b));
        sent_ar++;
      end
      if (m_awvalid_o && m_awready_i)
      begin
        if (aw_q.size() == 0)
        begin
          errors++;
          $display("aw channel sent an address with no request outstanding");
        end
        else
          check_value("aw_addr", aw_q.pop_front(), m_awaddr_o);
        got_aw++;
      end
      if (m_arvalid_o && m_arready_i)
      begin
        if (ar_q.size() == 0)
        begin
          errors++;
          $display("ar channel sent an address with no request outstanding");
        end
        else
          check_value("ar_addr", ar_q.pop_front(), m_araddr_o);
        got_ar++;
      end
      #1;
      m_awready_i = ($random(seed) & 1) == 1;
      m_arready_i = ($random(seed) & 1) == 1;
      // a pending request holds until taken
      if (acc_aw || !aw_req_v_i)
      begin
        aw_req_v_i        = (sent_aw < n) && (($random(seed) & 3) != 0);
        aw_req_i.cache_id = LG_NUM_DMA'($random(seed));
        aw_req_i.addr     = $random(seed);
      end
      if (acc_ar || !ar_req_v_i)
      begin
        ar_req_v_i        = (sent_ar < n) && (($random(seed) & 3) != 0);
        ar_req_i.cache_id = LG_NUM_DMA'($random(seed));
        ar_req_i.addr     = $random(seed);
      end
    end
    aw_req_v_i = 1'b0;
    ar_req_v_i = 1'b0;
    if (aw_q.size() != 0 || ar_q.size() != 0)
    begin
      errors++;
      $display("requests left in the model after traffic ended");
    end
  endtask

  initial
  begin
    repeat (TOTAL_TXN * 50) @(posedge aclk);
    $display("watchdog expired after %0d cycles, run did not finish", TOTAL_TXN * 50);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    aclk        = 1'b0;
    rst_n_i     = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    aw_req_i    = '0;
    aw_req_v_i  = 1'b0;
    m_awready_i = 1'b0;
    ar_req_i    = '0;
    ar_req_v_i  = 1'b0;
    m_arready_i = 1'b0;
    for (int i = 0; i < NUM_CSR; i++)
      csr_model[i] = '0;
    repeat (5) @(posedge aclk);
    #1;
    rst_n_i = 1'b1;

    // register readback, full then partial strobes
    for (int i = 0; i < NUM_CSR; i++)
      host_write(i, $random(seed), 4'hf);
    for (int i = 0; i < NUM_CSR; i++)
    begin
      host_read(i, rd_data);
      check_value($sformatf("csr%0d_readback", i), csr_model[i], rd_data);
    end
    for (int k = 0; k < 4; k++)
    begin
      wr_data = $random(seed);
      strb    = 4'($random(seed));
      host_write(CSR_SCRATCH, wr_data, strb);
      host_read(CSR_SCRATCH, rd_data);
      check_value("scratch_partial", csr_model[CSR_SCRATCH], rd_data);
    end

    // machine rom and unmapped reads
    for (int k = 0; k < 4; k++)
    begin
      wr_data = $random(seed);
      host_write(CSR_ROM_ADDR, wr_data, 4'hf);
      host_read(STATUS_ROM, rd_data);
      check_value("rom_lookup", MACHINE_ROM[wr_data[3:0]], rd_data);
    end
    host_read(6, rd_data);
    check_value("read_idx6", 32'd0, rd_data);
    host_read(7, rd_data);
    check_value("read_idx7", 32'd0, rd_data);

    // system reset hold and release
    m_awready_i = 1'b1;
    m_arready_i = 1'b1;
    host_write(CSR_RESET, 32'd0, 4'hf);
    repeat (RESET_DEPTH + 2) @(posedge aclk);
    check_value("aw_ready_in_reset", 32'd0, 32'(aw_req_ready_o));
    check_value("ar_ready_in_reset", 32'd0, 32'(ar_req_ready_o));
    #1;
    host_write(CSR_RESET, 32'd1, 4'hf);
    wait_release();

    base = $random(seed);
    host_write(CSR_DRAM_BASE, base, 4'hf);
    run_traffic(NUM_REQ, base);

    // park one entry per channel, then reset over it
    #1;
    m_awready_i = 1'b0;
    m_arready_i = 1'b0;
    aw_req_i    = {LG_NUM_DMA'($random(seed)), 32'($random(seed))};
    ar_req_i    = {LG_NUM_DMA'($random(seed)), 32'($random(seed))};
    aw_req_v_i  = 1'b1;
    ar_req_v_i  = 1'b1;
    @(posedge aclk);
    #1;
    aw_req_v_i = 1'b0;
    ar_req_v_i = 1'b0;
    @(posedge aclk);
    check_value("aw_valid_parked", 32'd1, 32'(m_awvalid_o));
    check_value("ar_valid_parked", 32'd1, 32'(m_arvalid_o));
    #1;
    host_write(CSR_RESET, 32'd0, 4'hf);
    repeat (RESET_DEPTH + 2) @(posedge aclk);
    check_value("aw_valid_reset", 32'd0, 32'(m_awvalid_o));
    check_value("ar_valid_reset", 32'd0, 32'(m_arvalid_o));
    check_value("aw_ready_reset", 32'd0, 32'(aw_req_ready_o));
    check_value("ar_ready_reset", 32'd0, 32'(ar_req_ready_o));
    #1;
    base = $random(seed);
    host_write(CSR_DRAM_BASE, base, 4'hf);
    host_write(CSR_RESET, 32'd1, 4'hf);
    wait_release();
    run_traffic(NUM_REQ2, base);

    errors += uut.props.fail_count;
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* tb/zynq_pl_props.sv */
`timescale 1ns/1ps

module zynq_pl_props
  import zynq_pkg::*;
(
  input logic                aclk,
  input logic                rst_n_i,
  input logic                s_bvalid_i,
  input logic                s_bready_i,
  input logic                s_rvalid_i,
  input logic                s_rready_i,
  input logic [M_ADDR_W-1:0] m_awaddr_i,
  input logic                m_awvalid_i,
  input logic                m_awready_i,
  input logic                pl_reset_i
);

  int fail_count = 0;

  // responses hold until the host takes them
  bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
    s_bvalid_i && !s_bready_i |=> s_bvalid_i)
    else
    begin
      $error("write response dropped before it was taken");
      fail_count++;
    end

  rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
    s_rvalid_i && !s_rready_i |=> s_rvalid_i)
    else
    begin
      $error("read data dropped before it was taken");
      fail_count++;
    end

  awaddr_stable: assert property (@(posedge aclk) disable iff (!rst_n_i)
    m_awvalid_i && !m_awready_i |=> $stable(m_awaddr_i))
    else
    begin
      $error("write address changed under back-pressure");
      fail_count++;
    end

  // low through reset, and the entry is gone once reset lets go
  awvalid_in_reset: assert property (@(posedge aclk) disable iff (!rst_n_i)
    pl_reset_i |-> !m_awvalid_i ##1 !m_awvalid_i)
    else
    begin
      $error("write address valid during or right after a PL reset");
      fail_count++;
    end

endmodule

bind zynq_pl_top zynq_pl_props props (
  .aclk       (aclk),
  .rst_n_i    (rst_n_i),
  .s_bvalid_i (s_bvalid_o),
  .s_bready_i (s_bready_i),
  .s_rvalid_i (s_rvalid_o),
  .s_rready_i (s_rready_i),
  .m_awaddr_i (m_awaddr_o),
  .m_awvalid_i(m_awvalid_o),
  .m_awready_i(m_awready_i),
  .pl_reset_i (pl_reset)
);

/* verilog/axil_csr_read.sv */
`timescale 1ns/1ps

module axil_csr_read
  import zynq_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst_n_i,
  input  csr_bank_t              csr_i,
  input  logic [AXIL_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i
);

  logic [CSR_IDX_W-1:0]   rd_idx;
  logic [ROM_ADDR_W-1:0]  rom_idx;
  logic [AXIL_DATA_W-1:0] rom_data;
  logic [AXIL_DATA_W-1:0] rd_word;
  logic [AXIL_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;
  logic                   rd_accept;

  assign rd_idx   = s_araddr_i[CSR_IDX_LSB +: CSR_IDX_W];
  assign rom_idx  = csr_i[CSR_ROM_ADDR][ROM_ADDR_W-1:0];
  assign rom_data = MACHINE_ROM[rom_idx];

  ////////////////////////////////////////
  // readback mux
  ////////////////////////////////////////
  always_comb
  begin
    rd_word = '0;
    if (rd_idx < CSR_IDX_W'(NUM_CSR))
      rd_word = csr_i[rd_idx];
    else if (rd_idx == CSR_IDX_W'(STATUS_ROM))
      rd_word = rom_data;
  end

  assign s_arready_o = ~rvalid_q;
  assign rd_accept   = s_arvalid_i & ~rvalid_q;

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rvalid_q <= 1'b0;
    else if (rd_accept)
      rvalid_q <= 1'b1;
    else if (s_rready_i)
      rvalid_q <= 1'b0;
  end

  // word is frozen until the host takes it
  always_ff @(posedge aclk)
  begin
    if (rd_accept)
      rdata_q <= rd_word;
  end

  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = 2'b00;
  assign s_rvalid_o = rvalid_q;

endmodule

/* verilog/axil_csr_write.sv */
`timescale 1ns/1ps

module axil_csr_write
  import zynq_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst_n_i,
  input  logic [AXIL_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_wdata_i,
  input  logic [AXIL_STRB_W-1:0] s_wstrb_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  output csr_bank_t              csr_o,
  output logic [NUM_CSR-1:0]     csr_new_o
);

  logic [CSR_IDX_W-1:0] wr_idx;
  logic                 wr_accept;
  csr_bank_t            csr_q;
  logic [NUM_CSR-1:0]   csr_new_q;
  logic                 bvalid_q;

  assign wr_idx = s_awaddr_i[CSR_IDX_LSB +: CSR_IDX_W];

  // address and data are taken together, one write in flight
  assign wr_accept   = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      csr_q     <= '0;
      csr_new_q <= '0;
    end
    else
    begin
      csr_new_q <= '0;
      // indices past the bank fall through untouched
      for (int r = 0; r < NUM_CSR; r++)
      begin
        if (wr_accept && wr_idx == CSR_IDX_W'(r))
        begin
          csr_new_q[r] <= 1'b1;
          for (int b = 0; b < AXIL_STRB_W; b++)
          begin
            if (s_wstrb_i[b])
              csr_q[r][8*b +: 8] <= s_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      bvalid_q <= 1'b0;
    else if (wr_accept)
      bvalid_q <= 1'b1;
    else if (s_bready_i)
      bvalid_q <= 1'b0;
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = 2'b00;
  assign csr_o      = csr_q;
  assign csr_new_o  = csr_new_q;

endmodule

/* verilog/dram_addr_remap.sv */
`timescale 1ns/1ps

module dram_addr_remap
  import zynq_pkg::*;
(
  input  logic                aclk,
  input  logic                rst_n_i,
  input  logic                pl_reset_i,
  input  logic [M_ADDR_W-1:0] dram_base_i,
  input  cache_req_t          req_i,
  input  logic                req_v_i,
  output logic                req_ready_o,
  output logic [M_ADDR_W-1:0] m_addr_o,
  output logic                m_valid_o,
  input  logic                m_ready_i
);

  dram_addr_u          dram_addr;
  logic                full_q;
  logic [M_ADDR_W-1:0] addr_q;
  logic                req_accept;

  ////////////////////////////////////////
  // cache id above the window offset
  ////////////////////////////////////////
  always_comb
  begin
    dram_addr.f.pad      = '0;
    dram_addr.f.cache_id = req_i.cache_id;
    dram_addr.f.offset   = req_i.addr[DRAM_ADDR_W-1:0]; 
  end

  // slot frees up in the same cycle the old entry leaves
  assign req_ready_o = ~pl_reset_i & (~full_q | m_ready_i);
  assign req_accept  = req_v_i & req_ready_o;

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      full_q <= 1'b0;
    else if (pl_reset_i)
      full_q <= 1'b0;
    else if (req_accept)
      full_q <= 1'b1;
    else if (m_ready_i)
      full_q <= 1'b0;
  end

  // base is sampled with the request
  always_ff @(posedge aclk)
  begin
    if (req_accept)
      addr_q <= dram_addr.flat + dram_base_i;
  end

  assign m_addr_o  = addr_q;
  assign m_valid_o = full_q & ~pl_reset_i;

endmodule

/* verilog/pl_reset_chain.sv */
`timescale 1ns/1ps

module pl_reset_chain #(
  parameter int RESET_DEPTH = 3
)
(
  input  logic aclk,
  input  logic rst_n_i,
  input  logic sys_resetn_i,
  output logic pl_reset_o
);

  logic [RESET_DEPTH-1:0] chain_q;

  // comes up held in reset until the host releases it
  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      chain_q <= '1;
    else
    begin
      chain_q[0] <= ~sys_resetn_i;
      for (int i = 1; i < RESET_DEPTH; i++)
        chain_q[i] <= chain_q[i-1];
    end
  end

  assign pl_reset_o = chain_q[RESET_DEPTH-1];

endmodule

/* verilog/zynq_pkg.sv */
package zynq_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_ADDR_W = 10;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int M_ADDR_W    = 32;

  // register index sits in address bits [4:2]
  localparam int CSR_IDX_LSB = 2;
  localparam int CSR_IDX_W   = 3;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////
  localparam int NUM_CSR       = 5;
  localparam int CSR_RESET     = 0;
  localparam int CSR_SCRATCH   = 1;
  localparam int CSR_DRAM_INIT = 2;
  localparam int CSR_DRAM_BASE = 3;
  localparam int CSR_ROM_ADDR  = 4;
  localparam int STATUS_ROM    = 5;

  // 128 MiB dram window, split by cache id
  localparam int DRAM_ADDR_W = 27;
  localparam int LG_NUM_DMA  = 4;
  localparam int DRAM_PAD_W  = M_ADDR_W - LG_NUM_DMA - DRAM_ADDR_W;

  localparam int ROM_ELS    = 16;
  localparam int ROM_ADDR_W = 4;

  // machine description words
  localparam logic [AXIL_DATA_W-1:0] MACHINE_ROM [ROM_ELS] = '{
    32'h0002_0100, 32'h0000_0020, 32'h0000_0010, 32'h0000_0008,
    32'h0000_0004, 32'h0000_0002, 32'h0000_0001, 32'h0000_0040,
    32'h0000_0400, 32'h0000_0008, 32'h0000_0080, 32'h0000_1000,
    32'h0000_0200, 32'h0800_0000, 32'h0000_0010, 32'h5a5a_c3c3
  };

  typedef logic [NUM_CSR-1:0][AXIL_DATA_W-1:0] csr_bank_t;

  typedef struct packed {
    logic [LG_NUM_DMA-1:0] cache_id;
    logic [M_ADDR_W-1:0]   addr;
  } cache_req_t;

  typedef struct packed {
    logic [DRAM_PAD_W-1:0]  pad;
    logic [LG_NUM_DMA-1:0]  cache_id;
    logic [DRAM_ADDR_W-1:0] offset;
  } dram_addr_fields_t;

  typedef union packed {
    logic [M_ADDR_W-1:0] flat;
    dram_addr_fields_t   f;
  } dram_addr_u;

endpackage

/* verilog/zynq_pl_top.sv */
`timescale 1ns/1ps

module zynq_pl_top
  import zynq_pkg::*;
#(
  parameter int RESET_DEPTH = 3
)
(
  input  logic                   aclk,
  input  logic                   rst_n_i,

  input  logic [AXIL_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_wdata_i,
  input  logic [AXIL_STRB_W-1:0] s_wstrb_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  input  logic [AXIL_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,

  input  cache_req_t             aw_req_i,
  input  logic                   aw_req_v_i,
  output logic                   aw_req_ready_o,
  output logic [M_ADDR_W-1:0]    m_awaddr_o,
  output logic                   m_awvalid_o,
  input  logic                   m_awready_i,

  input  cache_req_t             ar_req_i,
  input  logic                   ar_req_v_i,
  output logic                   ar_req_ready_o,
  output logic [M_ADDR_W-1:0]    m_araddr_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i
);

  csr_bank_t csr;
  logic      pl_reset;

  ////////////////////////////////////////
  // host register shell
  ////////////////////////////////////////
  // new-data strobes have no consumer in this design
  axil_csr_write csr_write (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .s_awaddr_i (s_awaddr_i),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i),
    .s_wstrb_i  (s_wstrb_i),
    .s_wvalid_i (s_wvalid_i),
    .s_wready_o (s_wready_o),
    .s_bresp_o  (s_bresp_o),
    .s_bvalid_o (s_bvalid_o),
    .s_bready_i (s_bready_i),
    .csr_o      (csr),
    .csr_new_o  ()
  );

  axil_csr_read csr_read (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .csr_i      (csr),
    .s_araddr_i (s_araddr_i),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o),
    .s_rresp_o  (s_rresp_o),
    .s_rvalid_o (s_rvalid_o),
    .s_rready_i (s_rready_i)
  );

  // bit 0 of register 0 is the active-low system reset
  pl_reset_chain #(
    .RESET_DEPTH(RESET_DEPTH)
  ) reset_chain (
    .aclk        (aclk),
    .rst_n_i     (rst_n_i),
    .sys_resetn_i(csr[CSR_RESET][0]),
    .pl_reset_o  (pl_reset)
  );

  ////////////////////////////////////////
  // dram address remap
  ////////////////////////////////////////
  dram_addr_remap aw_remap (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .pl_reset_i (pl_reset),
    .dram_base_i(csr[CSR_DRAM_BASE]),
    .req_i      (aw_req_i),
    .req_v_i    (aw_req_v_i),
    .req_ready_o(aw_req_ready_o),
    .m_addr_o   (m_awaddr_o),
    .m_valid_o  (m_awvalid_o),
    .m_ready_i  (m_awready_i)
  );

  dram_addr_remap ar_remap (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .pl_reset_i (pl_reset),
    .dram_base_i(csr[CSR_DRAM_BASE]),
    .req_i      (ar_req_i),
    .req_v_i    (ar_req_v_i),
    .req_ready_o(ar_req_ready_o),
    .m_addr_o   (m_araddr_o),
    .m_valid_o  (m_arvalid_o),
    .m_ready_i  (m_arready_i)
  );

endmodule
